/* files.f */
design/chdr_pkg.sv
design/sep_reg_pkg.sv
design/stream_ep_regs.sv
design/chdr_ingress_router.sv
design/chdr_egress_mux.sv
design/chdr_stream_endpoint.sv
sim/chdr_stream_endpoint_assert.sv
sim/tb_chdr_stream_endpoint.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_chdr_stream_endpoint -f files.f -o sim_tb \
  && ./obj_dir/sim_tb 2>&1 | tee sim.log \
  || { echo "Build or simulation run did not complete"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* sim/tb_chdr_stream_endpoint.sv */
`default_nettype none

module tb_chdr_stream_endpoint;
  timeunit 1ns;
  timeprecision 1ps;

  // Five tests of under 400 cycles each leave a wide margin
  localparam int TIMEOUT_CYCLES = 5000;
  localparam chdr_pkg::epid_t OWN_EPID = 16'h0042;
  localparam chdr_pkg::epid_t DST_EPID = 16'h0777;

  logic                       rfnoc_chdr_clk = 1'b0;
  logic                       rfnoc_chdr_rst;
  chdr_pkg::chdr_word_t       i_chdr_tdata;
  logic                       i_chdr_tlast;
  logic                       i_chdr_tvalid;
  logic                       o_chdr_tready;
  chdr_pkg::chdr_word_t       o_chdr_tdata;
  logic                       o_chdr_tlast;
  logic                       o_chdr_tvalid;
  logic                       i_chdr_tready;
  chdr_pkg::chdr_word_t       i_data_tdata  [sep_reg_pkg::NUM_DATA_I];
  logic                       i_data_tlast  [sep_reg_pkg::NUM_DATA_I];
  logic                       i_data_tvalid [sep_reg_pkg::NUM_DATA_I];
  logic                       o_data_tready [sep_reg_pkg::NUM_DATA_I];
  chdr_pkg::chdr_word_t       o_data_tdata  [sep_reg_pkg::NUM_DATA_O];
  logic                       o_data_tlast  [sep_reg_pkg::NUM_DATA_O];
  logic                       o_data_tvalid [sep_reg_pkg::NUM_DATA_O];
  logic                       i_data_tready [sep_reg_pkg::NUM_DATA_O];
  logic                       i_wb_cyc;
  logic                       i_wb_stb;
  logic                       i_wb_we;
  logic [sep_reg_pkg::REG_ADDR_W-1:0] i_wb_adr;
  sep_reg_pkg::wb_data_t      i_wb_dat;
  sep_reg_pkg::wb_data_t      o_wb_dat;
  logic                       o_wb_ack;
  logic                       o_route_err_stb;

  int   cycles = 0;
  int   err_pulses = 0;
  int   seed;
  logic bp_done;

  chdr_stream_endpoint u_dut (.*);

  always #4 rfnoc_chdr_clk = ~rfnoc_chdr_clk;

  always @(posedge rfnoc_chdr_clk) begin
    cycles <= cycles + 1;
    if (o_route_err_stb) begin
      err_pulses <= err_pulses + 1;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  // ------------------------------------------------------------
  // Expected values and compare tasks
  // ------------------------------------------------------------
  function automatic chdr_pkg::chdr_word_t build_hdr(input chdr_pkg::vc_t vc,
      input chdr_pkg::chdr_pkt_type_e pkt_type, input chdr_pkg::seq_num_t seq,
      input logic [15:0] len, input chdr_pkg::epid_t dst);
    chdr_pkg::chdr_word_t h;
    h = '0;
    h[chdr_pkg::VC_LSB +: 6]       = vc;
    h[chdr_pkg::PKT_TYPE_LSB +: 3] = pkt_type;
    h[chdr_pkg::SEQ_NUM_LSB +: 16] = seq;
    h[31:16]                       = len;
    h[chdr_pkg::DST_EPID_LSB +: 16] = dst;
    return h;
  endfunction

  // Payload words carry their source port and packet index
  function automatic chdr_pkg::chdr_word_t payload(input int p, input int k, input int b);
    return {8'hC0, 8'(p), 8'(k), 40'(b)};
  endfunction

  function automatic chdr_pkg::chdr_word_t src_hdr(input int p, input int k);
    return build_hdr(6'h2A, chdr_pkg::DATA, 16'h5A5A, {8'(p), 8'(k)}, 16'hDEAD);
  endfunction

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_word(input string name, input chdr_pkg::chdr_word_t exp, act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_reg(input string name, input sep_reg_pkg::wb_data_t exp, act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // ------------------------------------------------------------
  // Bus drivers
  // ------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [7:0] adr,
                           input sep_reg_pkg::wb_data_t wdat,
                           output sep_reg_pkg::wb_data_t rdat);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do begin
      @(negedge rfnoc_chdr_clk);
    end while (!o_wb_ack);
    rdat = o_wb_dat;
    @(posedge rfnoc_chdr_clk);
    #1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    // A second ack here would mean the access was served twice
    @(negedge rfnoc_chdr_clk);
    compare_bit("wb_single_ack", 1'b0, o_wb_ack);
    @(posedge rfnoc_chdr_clk);
    #1;
  endtask

  task automatic wb_write(input logic [7:0] adr, input sep_reg_pkg::wb_data_t dat);
    sep_reg_pkg::wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic check_reg(input string name, input logic [7:0] adr,
                           input sep_reg_pkg::wb_data_t exp);
    sep_reg_pkg::wb_data_t rdat;
    wb_access(1'b0, adr, '0, rdat);
    compare_reg(name, exp, rdat);
  endtask

  // Three-beat packet into the CHDR input
  // An exp_port of -1 means the packet is dropped
  task automatic send_ingress(input string name, input chdr_pkg::chdr_word_t hdr,
                              input int exp_port);
    chdr_pkg::chdr_word_t beat;
    // Only the target port is ready and a dropped packet sees no ready at all
    for (int q = 0; q < sep_reg_pkg::NUM_DATA_O; q++) begin
      i_data_tready[q] = (q == exp_port);
    end
    for (int b = 0; b < 3; b++) begin
      beat = (b == 0) ? hdr : payload(2, 0, b);
      i_chdr_tdata  = beat;
      i_chdr_tlast  = (b == 2);
      i_chdr_tvalid = 1'b1;
      @(negedge rfnoc_chdr_clk);
      compare_bit(name, 1'b1, o_chdr_tready);
      for (int q = 0; q < sep_reg_pkg::NUM_DATA_O; q++) begin
        compare_bit(name, (q == exp_port), o_data_tvalid[q]);
      end
      if (exp_port >= 0) begin
        compare_word(name, beat, o_data_tdata[exp_port]);
        compare_bit(name, (b == 2), o_data_tlast[exp_port]);
      end
      @(posedge rfnoc_chdr_clk);
      #1;
    end
    i_chdr_tvalid = 1'b0;
    i_chdr_tlast  = 1'b0;
    for (int q = 0; q < sep_reg_pkg::NUM_DATA_O; q++) begin
      i_data_tready[q] = 1'b1;
    end
  endtask

  task automatic send_port(input int p, input int npkt);
    for (int k = 0; k < npkt; k++) begin
      for (int b = 0; b < 3; b++) begin
        i_data_tdata[p]  = (b == 0) ? src_hdr(p, k) : payload(p, k, b);
        i_data_tlast[p]  = (b == 2);
        i_data_tvalid[p] = 1'b1;
        do begin
          @(negedge rfnoc_chdr_clk);
        end while (!o_data_tready[p]);
        @(posedge rfnoc_chdr_clk);
        #1;
      end
    end
    i_data_tvalid[p] = 1'b0;
    i_data_tlast[p]  = 1'b0;
  endtask

  // Checks whole packets on the CHDR output with the stamped header first
  task automatic collect(input string name, input int npkt, input int first_vc,
                         input logic alternate, input int seq0);
    int                   k [2];
    int                   v;
    chdr_pkg::chdr_word_t exp;
    k[0] = 0;
    k[1] = 0;
    for (int n = 0; n < npkt; n++) begin
      v = alternate ? (first_vc + n) % 2 : first_vc;
      for (int b = 0; b < 3; b++) begin
        do begin
          @(negedge rfnoc_chdr_clk);
        end while (!(o_chdr_tvalid && i_chdr_tready));
        if (b == 0) begin
          exp = build_hdr(chdr_pkg::vc_t'(v), chdr_pkg::DATA,
                          chdr_pkg::seq_num_t'(seq0 + n), {8'(v), 8'(k[v])}, DST_EPID);
        end else begin
          exp = payload(v, k[v], b);
        end
        compare_word(name, exp, o_chdr_tdata);
        compare_bit(name, (b == 2), o_chdr_tlast);
      end
      k[v] = k[v] + 1;
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic registers_rw();
    wb_write(sep_reg_pkg::REG_EPID_SELF, 32'h1234_5678);
    check_reg("registers_rw", sep_reg_pkg::REG_EPID_SELF, 32'h0000_5678);
    wb_write(sep_reg_pkg::REG_OSTRM_DST_EPID, 32'hABCD_0123);
    check_reg("registers_rw", sep_reg_pkg::REG_OSTRM_DST_EPID, 32'h0000_0123);
    check_reg("registers_rw", 8'h3C, 32'h0);
  endtask

  task automatic ingress_steering();
    chdr_pkg::chdr_pkt_type_e t;
    wb_write(sep_reg_pkg::REG_EPID_SELF, 32'(OWN_EPID));
    for (int i = 0; i < 2; i++) begin
      t = (i == 0) ? chdr_pkg::DATA : chdr_pkg::DATA_TS;
      send_ingress("ingress_steering", build_hdr(6'd0, t, 16'd7, 16'd24, OWN_EPID), 0);
      send_ingress("ingress_steering", build_hdr(6'd1, t, 16'd8, 16'd24, OWN_EPID), 1);
      // VC 5 is past the last port
      send_ingress("ingress_steering", build_hdr(6'd5, t, 16'd9, 16'd24, OWN_EPID), 0);
    end
  endtask

  task automatic ingress_filtering();
    int pulses0;
    pulses0 = err_pulses;
    send_ingress("ingress_filtering",
                 build_hdr(6'd1, chdr_pkg::DATA, 16'd3, 16'd24, OWN_EPID + 16'd1), -1);
    send_ingress("ingress_filtering",
                 build_hdr(6'd0, chdr_pkg::STRS, 16'd0, 16'd24, OWN_EPID), -1);
    @(posedge rfnoc_chdr_clk);
    #1;
    compare_reg("ingress_filtering", 32'(pulses0 + 1), 32'(err_pulses));
    check_reg("ingress_filtering", sep_reg_pkg::REG_ISTRM_ROUTE_ERR_CNT, 32'd1);
    check_reg("ingress_filtering", sep_reg_pkg::REG_ISTRM_DROP_CNT, 32'd1);
    wb_write(sep_reg_pkg::REG_RESET_AND_FLUSH, 32'h2);
    check_reg("ingress_flush", sep_reg_pkg::REG_ISTRM_ROUTE_ERR_CNT, 32'd0);
    check_reg("ingress_flush", sep_reg_pkg::REG_ISTRM_DROP_CNT, 32'd0);
  endtask

  task automatic egress_stamping();
    wb_write(sep_reg_pkg::REG_OSTRM_DST_EPID, 32'(DST_EPID));
    fork
      send_port(1, 3);
      collect("egress_stamping", 3, 1, 1'b0, 0);
    join
    check_reg("egress_stamping", sep_reg_pkg::REG_OSTRM_SEQ_NUM, 32'd3);
  endtask

  task automatic egress_arbitration();
    int rnd;
    bp_done = 1'b0;
    // Port 1 won last, so port 0 goes first
    fork
      send_port(0, 2);
      send_port(1, 2);
      begin
        collect("egress_arbitration", 4, 0, 1'b1, 3);
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          rnd = $random(seed);
          i_chdr_tready = rnd[0];
          @(posedge rfnoc_chdr_clk);
          #1;
        end
        i_chdr_tready = 1'b1;
      end
    join
    wb_write(sep_reg_pkg::REG_RESET_AND_FLUSH, 32'h1);
    fork
      send_port(0, 1);
      collect("egress_flush", 1, 0, 1'b0, 0);
    join
  endtask

  initial begin
    seed           = 52201;
    bp_done        = 1'b0;
    rfnoc_chdr_rst = 1'b1;
    i_chdr_tdata   = '0;
    i_chdr_tlast   = 1'b0;
    i_chdr_tvalid  = 1'b0;
    i_chdr_tready  = 1'b1;
    i_wb_cyc       = 1'b0;
    i_wb_stb       = 1'b0;
    i_wb_we        = 1'b0;
    i_wb_adr       = '0;
    i_wb_dat       = '0;
    for (int i = 0; i < 2; i++) begin
      i_data_tdata[i]  = '0;
      i_data_tlast[i]  = 1'b0;
      i_data_tvalid[i] = 1'b0;
      i_data_tready[i] = 1'b1;
    end
    repeat (5) @(posedge rfnoc_chdr_clk);
    #1;
    rfnoc_chdr_rst = 1'b0;
    registers_rw();
    ingress_steering();
    ingress_filtering();
    egress_stamping();
    egress_arbitration();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/chdr_stream_endpoint_assert.sv */
`default_nettype none

module chdr_stream_endpoint_assert (
  input wire logic                 rfnoc_chdr_clk,
  input wire logic                 rfnoc_chdr_rst,
  input wire chdr_pkg::chdr_word_t i_out_tdata,
  input wire logic                 i_out_tlast,
  input wire logic                 i_out_tvalid,
  input wire logic                 i_out_tready,
  input wire logic                 i_wb_cyc,
  input wire logic                 i_wb_stb,
  input wire logic                 i_wb_ack,
  input wire logic                 i_data_tvalid0,
  input wire logic                 i_data_tvalid1
);
  timeunit 1ns;
  timeprecision 1ps;

  // A stalled CHDR output beat must hold
  hold_stalled: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    i_out_tvalid && !i_out_tready |=> $stable(i_out_tdata) && $stable(i_out_tlast))
    else $error("CHDR output beat changed while stalled");

  ack_after_request: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else $error("Wishbone ack without a request in the cycle before");

  // Ingress steers each beat to a single port
  one_data_valid: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    !(i_data_tvalid0 && i_data_tvalid1))
    else $error("Both data outputs valid at once");

endmodule

bind chdr_stream_endpoint chdr_stream_endpoint_assert u_assert (
  .rfnoc_chdr_clk (rfnoc_chdr_clk),
  .rfnoc_chdr_rst (rfnoc_chdr_rst),
  .i_out_tdata    (o_chdr_tdata),
  .i_out_tlast    (o_chdr_tlast),
  .i_out_tvalid   (o_chdr_tvalid),
  .i_out_tready   (i_chdr_tready),
  .i_wb_cyc       (i_wb_cyc),
  .i_wb_stb       (i_wb_stb),
  .i_wb_ack       (o_wb_ack),
  .i_data_tvalid0 (o_data_tvalid[0]),
  .i_data_tvalid1 (o_data_tvalid[1])
);

`default_nettype wire

/* design/chdr_stream_endpoint.sv */
`default_nettype none

module chdr_stream_endpoint (
  input  logic                                rfnoc_chdr_clk,
  input  logic                                rfnoc_chdr_rst,
  // CHDR in
  input  chdr_pkg::chdr_word_t                i_chdr_tdata,
  input  logic                                i_chdr_tlast,
  input  logic                                i_chdr_tvalid,
  output logic                                o_chdr_tready,
  // CHDR out
  output chdr_pkg::chdr_word_t                o_chdr_tdata,
  output logic                                o_chdr_tlast,
  output logic                                o_chdr_tvalid,
  input  logic                                i_chdr_tready,
  // Data in
  input  chdr_pkg::chdr_word_t                i_data_tdata  [sep_reg_pkg::NUM_DATA_I],
  input  logic                                i_data_tlast  [sep_reg_pkg::NUM_DATA_I],
  input  logic                                i_data_tvalid [sep_reg_pkg::NUM_DATA_I],
  output logic                                o_data_tready [sep_reg_pkg::NUM_DATA_I],
  // Data out
  output chdr_pkg::chdr_word_t                o_data_tdata  [sep_reg_pkg::NUM_DATA_O],
  output logic                                o_data_tlast  [sep_reg_pkg::NUM_DATA_O],
  output logic                                o_data_tvalid [sep_reg_pkg::NUM_DATA_O],
  input  logic                                i_data_tready [sep_reg_pkg::NUM_DATA_O],
  // Wishbone register port
  input  logic                                i_wb_cyc,
  input  logic                                i_wb_stb,
  input  logic                                i_wb_we,
  input  logic [sep_reg_pkg::REG_ADDR_W-1:0]  i_wb_adr,
  input  sep_reg_pkg::wb_data_t               i_wb_dat,
  output sep_reg_pkg::wb_data_t               o_wb_dat,
  output logic                                o_wb_ack,
  output logic                                o_route_err_stb
);

  chdr_pkg::epid_t    epid_self;
  chdr_pkg::epid_t    dst_epid;
  chdr_pkg::seq_num_t seq_num;
  logic               istrm_flush;
  logic               ostrm_flush;
  logic               drop_stb;

  // ------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------
  stream_ep_regs u_regs (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_wb_cyc        (i_wb_cyc),
    .i_wb_stb        (i_wb_stb),
    .i_wb_we         (i_wb_we),
    .i_wb_adr        (i_wb_adr),
    .i_wb_dat        (i_wb_dat),
    .o_wb_dat        (o_wb_dat),
    .o_wb_ack        (o_wb_ack),
    .i_route_err_stb (o_route_err_stb),
    .i_drop_stb      (drop_stb),
    .i_seq_num       (seq_num),
    .o_epid_self     (epid_self),
    .o_dst_epid      (dst_epid),
    .o_istrm_flush   (istrm_flush),
    .o_ostrm_flush   (ostrm_flush)
  );

  // ------------------------------------------------------------
  // CHDR to data ports
  // ------------------------------------------------------------
  chdr_ingress_router u_ingress (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_flush         (istrm_flush),
    .i_chdr_tdata    (i_chdr_tdata),
    .i_chdr_tlast    (i_chdr_tlast),
    .i_chdr_tvalid   (i_chdr_tvalid),
    .o_chdr_tready   (o_chdr_tready),
    .i_epid_self     (epid_self),
    .o_data_tdata    (o_data_tdata),
    .o_data_tlast    (o_data_tlast),
    .o_data_tvalid   (o_data_tvalid),
    .i_data_tready   (i_data_tready),
    .o_route_err_stb (o_route_err_stb),
    .o_drop_stb      (drop_stb)
  );

  // Data ports to CHDR
  chdr_egress_mux u_egress (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_flush         (ostrm_flush),
    .i_data_tdata    (i_data_tdata),
    .i_data_tlast    (i_data_tlast),
    .i_data_tvalid   (i_data_tvalid),
    .o_data_tready   (o_data_tready),
    .i_dst_epid      (dst_epid),
    .o_chdr_tdata    (o_chdr_tdata),
    .o_chdr_tlast    (o_chdr_tlast),
    .o_chdr_tvalid   (o_chdr_tvalid),
    .i_chdr_tready   (i_chdr_tready),
    .o_seq_num       (seq_num)
  );

endmodule

`default_nettype wire

/* design/chdr_egress_mux.sv */
`default_nettype none

module chdr_egress_mux (
  input  logic                 rfnoc_chdr_clk,
  input  logic                 rfnoc_chdr_rst,
  input  logic                 i_flush,
  // Data in
  input  chdr_pkg::chdr_word_t i_data_tdata  [sep_reg_pkg::NUM_DATA_I],
  input  logic                 i_data_tlast  [sep_reg_pkg::NUM_DATA_I],
  input  logic                 i_data_tvalid [sep_reg_pkg::NUM_DATA_I],
  output logic                 o_data_tready [sep_reg_pkg::NUM_DATA_I],
  input  chdr_pkg::epid_t      i_dst_epid,
  // CHDR out
  output chdr_pkg::chdr_word_t o_chdr_tdata,
  output logic                 o_chdr_tlast,
  output logic                 o_chdr_tvalid,
  input  logic                 i_chdr_tready,
  output chdr_pkg::seq_num_t   o_seq_num
);

  typedef enum logic {
    ST_IDLE,
    ST_GRANT
  } state_e;

  state_e                         state;
  // Granted port, also remembers the last winner while idle
  logic [sep_reg_pkg::PORT_W-1:0] grant;
  logic [sep_reg_pkg::PORT_W-1:0] other;
  logic [sep_reg_pkg::PORT_W-1:0] pick;
  logic [sep_reg_pkg::PORT_W-1:0] cur;
  logic                           in_hdr;
  logic                           hdr;
  logic                           beat;

  // ------------------------------------------------------------
  // Round-robin select
  // ------------------------------------------------------------
  assign other = grant + 1'b1;
  assign pick  = i_data_tvalid[other] ? other : grant;
  assign cur   = (state == ST_IDLE) ? pick : grant;
  assign hdr   = (state == ST_IDLE) || in_hdr;
  assign beat  = o_chdr_tvalid && i_chdr_tready;

  assign o_chdr_tvalid = i_data_tvalid[cur];
  assign o_chdr_tlast  = i_data_tlast[cur];
  // Header beat gets the source port as VC and the egress routing
  assign o_chdr_tdata  = hdr ? chdr_pkg::set_route(i_data_tdata[cur], chdr_pkg::vc_t'(cur),
                                                   o_seq_num, i_dst_epid)
                             : i_data_tdata[cur];

  always_comb begin
    for (int i = 0; i < sep_reg_pkg::NUM_DATA_I; i++) begin
      o_data_tready[i] = i_chdr_tready && (cur == i);
    end
  end

  // ------------------------------------------------------------
  // Grant FSM and sequence counter
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || i_flush) begin
      state     <= ST_IDLE;
      grant     <= '0;
      in_hdr    <= 1'b0;
      o_seq_num <= '0;
    end else begin
      if (beat && o_chdr_tlast) begin
        o_seq_num <= o_seq_num + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          // Lock the choice as soon as valid shows, so the output holds under stall
          if (o_chdr_tvalid) begin
            grant  <= pick;
            in_hdr <= !beat;
            if (!(beat && o_chdr_tlast)) begin
              state <= ST_GRANT;
            end
          end
        end
        default: begin
          if (beat) begin
            in_hdr <= 1'b0;
            if (o_chdr_tlast) begin
              state <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/chdr_ingress_router.sv */
`default_nettype none

module chdr_ingress_router (
  input  logic                 rfnoc_chdr_clk,
  input  logic                 rfnoc_chdr_rst,
  input  logic                 i_flush,
  // CHDR in
  input  chdr_pkg::chdr_word_t i_chdr_tdata,
  input  logic                 i_chdr_tlast,
  input  logic                 i_chdr_tvalid,
  output logic                 o_chdr_tready,
  input  chdr_pkg::epid_t      i_epid_self,
  // Data out, one stream per VC
  output chdr_pkg::chdr_word_t o_data_tdata  [sep_reg_pkg::NUM_DATA_O],
  output logic                 o_data_tlast  [sep_reg_pkg::NUM_DATA_O],
  output logic                 o_data_tvalid [sep_reg_pkg::NUM_DATA_O],
  input  logic                 i_data_tready [sep_reg_pkg::NUM_DATA_O],
  // Error strobes
  output logic                 o_route_err_stb,
  output logic                 o_drop_stb
);

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_FORWARD,
    ST_DROP
  } state_e;

  state_e                         state;
  logic [sep_reg_pkg::PORT_W-1:0] sel_port;
  logic [sep_reg_pkg::PORT_W-1:0] hdr_port;
  logic [sep_reg_pkg::PORT_W-1:0] out_port;
  chdr_pkg::vc_t                  hdr_vc;
  chdr_pkg::chdr_pkt_type_e       hdr_type;
  logic                           is_data;
  logic                           hdr_fwd;
  logic                           fwd;
  logic                           beat;

  // ------------------------------------------------------------
  // Header decode, only meaningful on the first beat
  // ------------------------------------------------------------
  assign hdr_vc   = chdr_pkg::get_vc(i_chdr_tdata);
  assign hdr_type = chdr_pkg::get_pkt_type(i_chdr_tdata);
  assign is_data  = (hdr_type == chdr_pkg::DATA) || (hdr_type == chdr_pkg::DATA_TS);
  assign hdr_fwd  = is_data && (chdr_pkg::get_dst_epid(i_chdr_tdata) == i_epid_self);
  // Out-of-range VC falls back to port 0
  assign hdr_port = (hdr_vc < sep_reg_pkg::NUM_DATA_O) ? hdr_vc[sep_reg_pkg::PORT_W-1:0] : '0;

  assign fwd      = (state == ST_HEADER) ? hdr_fwd : (state == ST_FORWARD);
  assign out_port = (state == ST_HEADER) ? hdr_port : sel_port;
  assign beat     = i_chdr_tvalid && o_chdr_tready;

  // Dropped beats are swallowed at full rate
  assign o_chdr_tready = fwd ? i_data_tready[out_port] : 1'b1;

  always_comb begin
    for (int i = 0; i < sep_reg_pkg::NUM_DATA_O; i++) begin
      o_data_tdata[i]  = i_chdr_tdata;
      o_data_tlast[i]  = i_chdr_tlast;
      o_data_tvalid[i] = fwd && i_chdr_tvalid && (out_port == i);
    end
  end

  // ------------------------------------------------------------
  // Packet FSM, destination is held until tlast
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || i_flush) begin
      state           <= ST_HEADER;
      sel_port        <= '0;
      o_route_err_stb <= 1'b0;
      o_drop_stb      <= 1'b0;
    end else begin
      o_route_err_stb <= 1'b0;
      o_drop_stb      <= 1'b0;
      if (beat) begin
        case (state)
          ST_HEADER: begin
            sel_port <= hdr_port;
            if (!hdr_fwd) begin
              o_route_err_stb <= is_data;
              o_drop_stb      <= !is_data;
            end
            if (!i_chdr_tlast) begin
              state <= hdr_fwd ? ST_FORWARD : ST_DROP;
            end
          end
          default: begin
            if (i_chdr_tlast) begin
              state <= ST_HEADER;
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/stream_ep_regs.sv */
`default_nettype none

module stream_ep_regs (
  input  logic                                rfnoc_chdr_clk,
  input  logic                                rfnoc_chdr_rst,
  // Wishbone slave
  input  logic                                i_wb_cyc,
  input  logic                                i_wb_stb,
  input  logic                                i_wb_we,
  input  logic [sep_reg_pkg::REG_ADDR_W-1:0]  i_wb_adr,
  input  sep_reg_pkg::wb_data_t               i_wb_dat,
  output sep_reg_pkg::wb_data_t               o_wb_dat,
  output logic                                o_wb_ack,
  // Status from the datapaths
  input  logic                                i_route_err_stb,
  input  logic                                i_drop_stb,
  input  chdr_pkg::seq_num_t                  i_seq_num,
  // Settings to the datapaths
  output chdr_pkg::epid_t                     o_epid_self,
  output chdr_pkg::epid_t                     o_dst_epid,
  output logic                                o_istrm_flush,
  output logic                                o_ostrm_flush
);

  logic                       req;
  sep_reg_pkg::sep_reg_addr_e addr;
  sep_reg_pkg::cnt_t          route_err_cnt;
  sep_reg_pkg::cnt_t          drop_cnt;

  // Ack masks the second cycle so each request is served once
  assign req  = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign addr = sep_reg_pkg::sep_reg_addr_e'(i_wb_adr);

  // ------------------------------------------------------------
  // Writes, ack and flush strobes
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      o_wb_ack      <= 1'b0;
      o_epid_self   <= '0;
      o_dst_epid    <= '0;
      o_istrm_flush <= 1'b0;
      o_ostrm_flush <= 1'b0;
    end else begin
      o_wb_ack      <= req;
      o_istrm_flush <= 1'b0;
      o_ostrm_flush <= 1'b0;
      if (req && i_wb_we) begin
        case (addr)
          sep_reg_pkg::REG_EPID_SELF: begin
            o_epid_self <= i_wb_dat[15:0];
          end
          sep_reg_pkg::REG_RESET_AND_FLUSH: begin
            o_ostrm_flush <= i_wb_dat[0];
            o_istrm_flush <= i_wb_dat[1];
          end
          sep_reg_pkg::REG_OSTRM_DST_EPID: begin
            o_dst_epid <= i_wb_dat[15:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read data is presented together with the ack
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      o_wb_dat <= '0;
    end else if (req && !i_wb_we) begin
      case (addr)
        sep_reg_pkg::REG_EPID_SELF:
          o_wb_dat <= sep_reg_pkg::wb_data_t'(o_epid_self);
        sep_reg_pkg::REG_OSTRM_DST_EPID:
          o_wb_dat <= sep_reg_pkg::wb_data_t'(o_dst_epid);
        sep_reg_pkg::REG_OSTRM_SEQ_NUM:
          o_wb_dat <= sep_reg_pkg::wb_data_t'(i_seq_num);
        sep_reg_pkg::REG_ISTRM_ROUTE_ERR_CNT:
          o_wb_dat <= route_err_cnt;
        sep_reg_pkg::REG_ISTRM_DROP_CNT:
          o_wb_dat <= drop_cnt;
        default:
          o_wb_dat <= '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Ingress error counters
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || o_istrm_flush) begin
      route_err_cnt <= '0;
      drop_cnt      <= '0;
    end else begin
      if (i_route_err_stb) begin
        route_err_cnt <= route_err_cnt + 1'b1;
      end
      if (i_drop_stb) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/sep_reg_pkg.sv */
`default_nettype none

package sep_reg_pkg;

  // Data ports on each side of the endpoint
  localparam int NUM_DATA_I = 2;
  localparam int NUM_DATA_O = 2;

  // Index width of a data port, both sides have the same count
  localparam int PORT_W = $clog2(NUM_DATA_O);

  localparam int REG_ADDR_W = 8;

  typedef logic [31:0] wb_data_t;
  typedef logic [31:0] cnt_t;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_EPID_SELF           = 8'h00,  // RW
    REG_RESET_AND_FLUSH     = 8'h04,  // W strobe, [0] egress, [1] ingress
    REG_OSTRM_DST_EPID      = 8'h08,  // RW
    REG_OSTRM_SEQ_NUM       = 8'h0C,  // R, next sequence number
    REG_ISTRM_ROUTE_ERR_CNT = 8'h10,  // R
    REG_ISTRM_DROP_CNT      = 8'h14   // R
  } sep_reg_addr_e;

endpackage

`default_nettype wire

/* design/chdr_pkg.sv */
`default_nettype none

package chdr_pkg;

  // One beat of the 64-bit CHDR stream
  typedef logic [63:0] chdr_word_t;

  typedef logic [5:0]  vc_t;
  typedef logic [15:0] epid_t;
  typedef logic [15:0] seq_num_t;

  // Packet type field of the header
  typedef enum logic [2:0] {
    MGMT    = 3'd0,
    STRS    = 3'd1,
    STRC    = 3'd2,
    CTRL    = 3'd4,
    DATA    = 3'd6,
    DATA_TS = 3'd7
  } chdr_pkt_type_e;

  // Low bit of each header field
  localparam int VC_LSB       = 58;
  localparam int PKT_TYPE_LSB = 53;
  localparam int SEQ_NUM_LSB  = 32;
  localparam int DST_EPID_LSB = 0;

  function automatic vc_t get_vc(input chdr_word_t hdr);
    return hdr[VC_LSB +: $bits(vc_t)];
  endfunction

  function automatic chdr_pkt_type_e get_pkt_type(input chdr_word_t hdr);
    return chdr_pkt_type_e'(hdr[PKT_TYPE_LSB +: $bits(chdr_pkt_type_e)]);
  endfunction

  function automatic epid_t get_dst_epid(input chdr_word_t hdr);
    return hdr[DST_EPID_LSB +: $bits(epid_t)];
  endfunction

  // Overwrites VC, sequence number and destination, keeps all other bits
  function automatic chdr_word_t set_route(input chdr_word_t hdr, input vc_t vc,
                                           input seq_num_t seq, input epid_t dst);
    chdr_word_t w;
    w = hdr;
    w[VC_LSB +: $bits(vc_t)]             = vc;
    w[SEQ_NUM_LSB +: $bits(seq_num_t)]   = seq;
    w[DST_EPID_LSB +: $bits(epid_t)]     = dst;
    return w;
  endfunction

endpackage

`default_nettype wire
